// ==== hdl/packet_router_config.svh ====
`ifndef PACKET_ROUTER_CONFIG_SVH
`define PACKET_ROUTER_CONFIG_SVH

`default_nettype none

// buffer depth is 2**PR_BUF_AW words
`define PR_BUF_AW 9

// flag positions inside a stream word
`define PR_SOF_BIT 32
`define PR_EOF_BIT 33

// header capture window
`define PR_HDR_WORDS  13    // ethernet, ip, udp and vrt words plus one spare
`define PR_DSP_OFFSET 11    // first captured word handed to the dsp

// udp data packet match values
`define PR_ETHERTYPE_IP  16'h0800
`define PR_PROTO_UDP     8'h11
`define PR_UDP_DATA_PORT 16'd49153

`default_nettype wire

`endif

// ==== hdl/packet_router_pkg.sv ====
`include "packet_router_config.svh"

`default_nettype none

package packet_router_pkg;

    typedef logic [31:0]           payload_t;
    typedef logic [35:0]           frame_t;     // {2'b00, eof, sof, payload}
    typedef logic [`PR_BUF_AW-1:0] buf_addr_t;

    ////////////////////
    // frame helpers
    ////////////////////

    function automatic logic is_sof(input frame_t f);
        return f[`PR_SOF_BIT];
    endfunction

    function automatic logic is_eof(input frame_t f);
        return f[`PR_EOF_BIT];
    endfunction

    // unused top bits stay zero
    function automatic frame_t make_frame(input logic sof, input logic eof, input payload_t pl);
        frame_t f;
        f              = '0;
        f[31:0]        = pl;
        f[`PR_SOF_BIT] = sof;
        f[`PR_EOF_BIT] = eof;
        return f;
    endfunction

endpackage

`default_nettype wire

// ==== hdl/stream_combiner.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_combiner import packet_router_pkg::*; (
    input  wire         stream_clk,
    input  wire         stream_rst,
    // input a, preferred when idle
    input  wire frame_t a_data_i,
    input  wire         a_valid_i,
    output logic        a_ready_o,
    // input b
    input  wire frame_t b_data_i,
    input  wire         b_valid_i,
    output logic        b_ready_o,
    // combined stream
    output frame_t      data_o,
    output logic        valid_o,
    input  wire         ready_i
);

    typedef enum logic [1:0] {
        GNT_IDLE,
        GNT_A,
        GNT_B
    } gnt_t;

    gnt_t gnt_q;
    logic sel_b;    // b drives the output this cycle
    logic xfer;

    always_comb begin
        case (gnt_q)
            GNT_A:   sel_b = 1'b0;
            GNT_B:   sel_b = 1'b1;
            default: sel_b = ~a_valid_i & b_valid_i;   // idle, a wins ties
        endcase
    end

    assign data_o    = sel_b ? b_data_i : a_data_i;
    assign valid_o   = sel_b ? b_valid_i : a_valid_i;
    assign a_ready_o = ready_i & ~sel_b;
    assign b_ready_o = ready_i & sel_b;

    assign xfer = valid_o & ready_i;

    // lock onto the source from sof until its eof has gone out
    always_ff @(posedge stream_clk) begin
        if (stream_rst) begin
            gnt_q <= GNT_IDLE;
        end else if (xfer) begin
            if (is_eof(data_o)) begin
                gnt_q <= GNT_IDLE;
            end else if (gnt_q == GNT_IDLE && is_sof(data_o)) begin
                gnt_q <= sel_b ? GNT_B : GNT_A;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/com_inspector.sv ====
`timescale 1ns/1ps
`include "packet_router_config.svh"
`default_nettype none

module com_inspector import packet_router_pkg::*; (
    input  wire         stream_clk,
    input  wire         stream_rst,
    // communication input
    input  wire frame_t com_data_i,
    input  wire         com_valid_i,
    output logic        com_ready_o,
    // udp data toward the dsp
    output frame_t      dsp_data_o,
    output logic        dsp_valid_o,
    input  wire         dsp_ready_i,
    // everything else toward the cpu
    output frame_t      cpu_data_o,
    output logic        cpu_valid_o,
    input  wire         cpu_ready_i
);

    localparam int HDR_WORDS  = `PR_HDR_WORDS;
    localparam int DSP_OFFSET = `PR_DSP_OFFSET;
    localparam int CNT_W      = $clog2(HDR_WORDS + 1);

    typedef enum logic [2:0] {
        S_READ_PRE,     // waiting for sof
        S_READ_HDR,
        S_DSP_REGS,
        S_DSP_LIVE,
        S_CPU_REGS,
        S_CPU_LIVE
    } state_t;

    state_t           state_q;
    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] cnt_next;
    logic             hdr_full;     // current word is the last of the window
    frame_t           hdr_q [HDR_WORDS];
    frame_t           hdr_word;
    logic             is_udp_data;
    logic             com_xfer;
    logic             dsp_xfer;
    logic             cpu_xfer;
    logic             capture;

    assign cnt_next = cnt_q + 1'b1;
    assign hdr_full = (cnt_next == CNT_W'(HDR_WORDS));
    assign hdr_word = hdr_q[cnt_q];

    // ipv4 ethertype, udp protocol, data port, non-zero vrt header
    assign is_udp_data = (hdr_q[3][15:0]  == `PR_ETHERTYPE_IP)
                       & (hdr_q[6][23:16] == `PR_PROTO_UDP)
                       & (hdr_q[9][15:0]  == `PR_UDP_DATA_PORT)
                       & (hdr_q[11][31:0] != 32'h0);

    ////////////////////
    // stream muxing
    ////////////////////

    always_comb begin
        dsp_data_o  = com_data_i;
        dsp_valid_o = 1'b0;
        cpu_data_o  = com_data_i;
        cpu_valid_o = 1'b0;
        case (state_q)
            S_READ_PRE, S_READ_HDR: com_ready_o = 1'b1;
            S_DSP_REGS: begin
                com_ready_o = 1'b0;
                dsp_data_o  = make_frame(cnt_q == CNT_W'(DSP_OFFSET), 1'b0, hdr_word[31:0]);
                dsp_valid_o = 1'b1;
            end
            S_DSP_LIVE: begin
                com_ready_o = dsp_ready_i;
                dsp_valid_o = com_valid_i;
            end
            S_CPU_REGS: begin
                com_ready_o = 1'b0;
                cpu_data_o  = hdr_word;     // keeps its own flags
                cpu_valid_o = 1'b1;
            end
            S_CPU_LIVE: begin
                com_ready_o = cpu_ready_i;
                cpu_valid_o = com_valid_i;
            end
            default: com_ready_o = 1'b0;
        endcase
    end

    assign com_xfer = com_valid_i & com_ready_o;
    assign dsp_xfer = dsp_valid_o & dsp_ready_i;
    assign cpu_xfer = cpu_valid_o & cpu_ready_i;
    assign capture  = com_xfer & ((state_q == S_READ_PRE & is_sof(com_data_i))
                               | (state_q == S_READ_HDR));

    always_ff @(posedge stream_clk) begin
        if (capture) begin
            hdr_q[cnt_q] <= com_data_i;
        end
    end

    ////////////////////
    // control
    ////////////////////

    always_ff @(posedge stream_clk) begin
        if (stream_rst) begin
            state_q <= S_READ_PRE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                S_READ_PRE: begin
                    if (capture && is_eof(com_data_i)) begin   // one word packet
                        state_q <= S_CPU_REGS;
                    end else if (capture) begin
                        cnt_q   <= cnt_next;
                        state_q <= S_READ_HDR;
                    end
                end
                S_READ_HDR: begin
                    if (capture) begin
                        if (hdr_full && !is_eof(com_data_i) && is_udp_data) begin
                            cnt_q   <= CNT_W'(DSP_OFFSET);
                            state_q <= S_DSP_REGS;
                        end else if (hdr_full || is_eof(com_data_i)) begin
                            cnt_q   <= '0;
                            state_q <= S_CPU_REGS;
                        end else begin
                            cnt_q <= cnt_next;
                        end
                    end
                end
                S_DSP_REGS: begin
                    if (dsp_xfer) begin
                        cnt_q <= hdr_full ? '0 : cnt_next;
                        if (hdr_full) state_q <= S_DSP_LIVE;
                    end
                end
                S_DSP_LIVE: begin
                    if (dsp_xfer && is_eof(com_data_i)) state_q <= S_READ_PRE;
                end
                S_CPU_REGS: begin
                    if (cpu_xfer) begin
                        cnt_q <= (is_eof(hdr_word) || hdr_full) ? '0 : cnt_next;
                        if (is_eof(hdr_word)) begin
                            state_q <= S_READ_PRE;      // whole packet was captured
                        end else if (hdr_full) begin
                            state_q <= S_CPU_LIVE;
                        end
                    end
                end
                S_CPU_LIVE: begin
                    if (cpu_xfer && is_eof(com_data_i)) state_q <= S_READ_PRE;
                end
                default: state_q <= S_READ_PRE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/cpu_inp_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_inp_buffer import packet_router_pkg::*; (
    input  wire            stream_clk,
    input  wire            stream_rst,
    // inspected packets
    input  wire frame_t    data_i,
    input  wire            valid_i,
    output logic           ready_o,
    // cpu handshake
    input  wire            cpu_inp_release_i,
    output logic           cpu_inp_done_o,
    output buf_addr_t      cpu_inp_count_o,
    // cpu read port
    input  wire buf_addr_t cpu_rd_addr_i,
    output payload_t       cpu_rd_data_o
);

    localparam int DEPTH = 2 ** $bits(buf_addr_t);

    typedef enum logic [1:0] {
        WAIT_SOF,
        WAIT_EOF,
        WAIT_REL_HI,
        WAIT_REL_LO
    } state_t;

    state_t    state_q;
    buf_addr_t wr_addr_q;   // doubles as the line count
    payload_t  mem [DEPTH];
    logic      xfer;
    logic      wr_en;

    assign ready_o         = (state_q == WAIT_SOF) || (state_q == WAIT_EOF);
    assign xfer            = valid_i & ready_o;
    assign wr_en           = xfer & ((state_q == WAIT_EOF) | is_sof(data_i));
    assign cpu_inp_done_o  = (state_q == WAIT_REL_HI);
    assign cpu_inp_count_o = wr_addr_q;

    always_ff @(posedge stream_clk) begin
        if (wr_en) begin
            mem[wr_addr_q] <= data_i[31:0];
        end
        cpu_rd_data_o <= mem[cpu_rd_addr_i];    // one cycle read latency
    end

    always_ff @(posedge stream_clk) begin
        if (stream_rst) begin
            state_q   <= WAIT_SOF;
            wr_addr_q <= '0;
        end else begin
            if (wr_en) wr_addr_q <= wr_addr_q + 1'b1;
            case (state_q)
                WAIT_SOF: begin
                    if (wr_en) state_q <= is_eof(data_i) ? WAIT_REL_HI : WAIT_EOF;
                end
                WAIT_EOF: begin
                    if (xfer && is_eof(data_i)) state_q <= WAIT_REL_HI;
                end
                WAIT_REL_HI: begin
                    if (cpu_inp_release_i) state_q <= WAIT_REL_LO;
                end
                WAIT_REL_LO: begin
                    if (!cpu_inp_release_i) begin
                        wr_addr_q <= '0;    // count clears once the cpu lets go
                        state_q   <= WAIT_SOF;
                    end
                end
                default: state_q <= WAIT_SOF;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/cpu_out_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_out_buffer import packet_router_pkg::*; (
    input  wire            stream_clk,
    input  wire            stream_rst,
    // cpu write port
    input  wire            cpu_wr_en_i,
    input  wire buf_addr_t cpu_wr_addr_i,
    input  wire payload_t  cpu_wr_data_i,
    // cpu handshake
    input  wire buf_addr_t cpu_out_count_i,
    input  wire            cpu_out_start_i,
    output logic           cpu_out_idle_o,
    // framed packet out
    output frame_t         data_o,
    output logic           valid_o,
    input  wire            ready_i
);

    localparam int DEPTH = 2 ** $bits(buf_addr_t);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_START_LO,
        UNLOAD
    } state_t;

    state_t    state_q;
    buf_addr_t count_q;
    buf_addr_t rd_addr_q;   // next word to fetch, runs one ahead of the output
    payload_t  mem [DEPTH];
    payload_t  rd_q;
    logic      vld_q;
    logic      sof_q;
    logic      eof_q;
    logic      fetch;
    logic      xfer;

    assign xfer           = vld_q & ready_i;
    assign fetch          = (state_q == UNLOAD) & (~vld_q | (ready_i & ~eof_q));
    assign valid_o        = vld_q;
    assign data_o         = make_frame(sof_q, eof_q, rd_q);
    assign cpu_out_idle_o = (state_q == IDLE);

    always_ff @(posedge stream_clk) begin
        if (cpu_wr_en_i) begin
            mem[cpu_wr_addr_i] <= cpu_wr_data_i;
        end
        if (fetch) begin
            rd_q <= mem[rd_addr_q];     // held while the sink stalls
        end
    end

    always_ff @(posedge stream_clk) begin
        if (stream_rst) begin
            state_q   <= IDLE;
            count_q   <= '0;
            rd_addr_q <= '0;
            vld_q     <= 1'b0;
            sof_q     <= 1'b0;
            eof_q     <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    count_q   <= cpu_out_count_i;
                    rd_addr_q <= '0;
                    if (cpu_out_start_i) state_q <= WAIT_START_LO;
                end
                WAIT_START_LO: begin
                    if (!cpu_out_start_i) state_q <= UNLOAD;
                end
                UNLOAD: begin
                    if (xfer && eof_q) state_q <= IDLE;
                end
                default: state_q <= IDLE;
            endcase

            // output register stage
            if (fetch) begin
                rd_addr_q <= rd_addr_q + 1'b1;
                vld_q     <= 1'b1;
                sof_q     <= (rd_addr_q == '0);
                eof_q     <= (rd_addr_q == count_q - 1'b1);
            end else if (xfer) begin
                vld_q <= 1'b0;  // last word has left
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/packet_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module packet_router import packet_router_pkg::*; (
    input  wire            stream_clk,
    input  wire            stream_rst,

    // streams into the router
    input  wire frame_t    eth_inp_data_i,
    input  wire            eth_inp_valid_i,
    output logic           eth_inp_ready_o,
    input  wire frame_t    ser_inp_data_i,
    input  wire            ser_inp_valid_i,
    output logic           ser_inp_ready_o,

    // streams out of the router
    output frame_t         eth_out_data_o,
    output logic           eth_out_valid_o,
    input  wire            eth_out_ready_i,
    output frame_t         ser_out_data_o,
    output logic           ser_out_valid_o,
    input  wire            ser_out_ready_i,
    output frame_t         dsp_out_data_o,
    output logic           dsp_out_valid_o,
    input  wire            dsp_out_ready_i,

    input  wire            eth_link_up_i,   // ethernet ready governs com out

    // cpu input buffer
    input  wire            cpu_inp_release_i,
    output logic           cpu_inp_done_o,
    output buf_addr_t      cpu_inp_count_o,
    input  wire buf_addr_t cpu_rd_addr_i,
    output payload_t       cpu_rd_data_o,

    // cpu output buffer
    input  wire            cpu_wr_en_i,
    input  wire buf_addr_t cpu_wr_addr_i,
    input  wire payload_t  cpu_wr_data_i,
    input  wire buf_addr_t cpu_out_count_i,
    input  wire            cpu_out_start_i,
    output logic           cpu_out_idle_o
);

    frame_t com_inp_data;
    logic   com_inp_valid;
    logic   com_inp_ready;
    frame_t cpu_inp_data;
    logic   cpu_inp_valid;
    logic   cpu_inp_ready;
    frame_t com_out_data;
    logic   com_out_valid;
    logic   com_out_ready;

    ////////////////////
    // input combining
    ////////////////////

    stream_combiner com_combiner_inst (
        .stream_clk (stream_clk),
        .stream_rst (stream_rst),
        .a_data_i   (eth_inp_data_i),
        .a_valid_i  (eth_inp_valid_i),
        .a_ready_o  (eth_inp_ready_o),
        .b_data_i   (ser_inp_data_i),
        .b_valid_i  (ser_inp_valid_i),
        .b_ready_o  (ser_inp_ready_o),
        .data_o     (com_inp_data),
        .valid_o    (com_inp_valid),
        .ready_i    (com_inp_ready)
    );

    ////////////////////
    // header decode
    ////////////////////

    com_inspector com_inspector_inst (
        .stream_clk  (stream_clk),
        .stream_rst  (stream_rst),
        .com_data_i  (com_inp_data),
        .com_valid_i (com_inp_valid),
        .com_ready_o (com_inp_ready),
        .dsp_data_o  (dsp_out_data_o),
        .dsp_valid_o (dsp_out_valid_o),
        .dsp_ready_i (dsp_out_ready_i),
        .cpu_data_o  (cpu_inp_data),
        .cpu_valid_o (cpu_inp_valid),
        .cpu_ready_i (cpu_inp_ready)
    );

    ////////////////////
    // result sinks
    ////////////////////

    cpu_inp_buffer cpu_inp_buffer_inst (
        .stream_clk        (stream_clk),
        .stream_rst        (stream_rst),
        .data_i            (cpu_inp_data),
        .valid_i           (cpu_inp_valid),
        .ready_o           (cpu_inp_ready),
        .cpu_inp_release_i (cpu_inp_release_i),
        .cpu_inp_done_o    (cpu_inp_done_o),
        .cpu_inp_count_o   (cpu_inp_count_o),
        .cpu_rd_addr_i     (cpu_rd_addr_i),
        .cpu_rd_data_o     (cpu_rd_data_o)
    );

    cpu_out_buffer cpu_out_buffer_inst (
        .stream_clk      (stream_clk),
        .stream_rst      (stream_rst),
        .cpu_wr_en_i     (cpu_wr_en_i),
        .cpu_wr_addr_i   (cpu_wr_addr_i),
        .cpu_wr_data_i   (cpu_wr_data_i),
        .cpu_out_count_i (cpu_out_count_i),
        .cpu_out_start_i (cpu_out_start_i),
        .cpu_out_idle_o  (cpu_out_idle_o),
        .data_o          (com_out_data),
        .valid_o         (com_out_valid),
        .ready_i         (com_out_ready)
    );

    // both links see the same packet, the live one paces it
    assign eth_out_data_o  = com_out_data;
    assign eth_out_valid_o = com_out_valid;
    assign ser_out_data_o  = com_out_data;
    assign ser_out_valid_o = com_out_valid;
    assign com_out_ready   = eth_link_up_i ? eth_out_ready_i : ser_out_ready_i;

endmodule

`default_nettype wire

// ==== verif/packet_router_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module packet_router_props import packet_router_pkg::*; (
    input wire         stream_clk,
    input wire         stream_rst,
    input wire frame_t eth_out_data_o,
    input wire         eth_out_valid_o,
    input wire         eth_out_ready_i,
    input wire frame_t ser_out_data_o,
    input wire         ser_out_valid_o,
    input wire         ser_out_ready_i,
    input wire frame_t dsp_out_data_o,
    input wire         dsp_out_valid_o,
    input wire         dsp_out_ready_i,
    input wire         eth_link_up_i,
    input wire         cpu_inp_release_i,
    input wire         cpu_inp_done_o
);

    int   assert_fail_cnt = 0;
    logic out_ready;    // whichever link paces the shared output

    assign out_ready = eth_link_up_i ? eth_out_ready_i : ser_out_ready_i;

    ////////////////////
    // stream protocol
    ////////////////////

    eth_out_hold: assert property (@(posedge stream_clk) disable iff (stream_rst)
        eth_out_valid_o && !out_ready |=> eth_out_valid_o && $stable(eth_out_data_o))
        else begin assert_fail_cnt++; $error("eth_out word changed while stalled"); end

    ser_out_hold: assert property (@(posedge stream_clk) disable iff (stream_rst)
        ser_out_valid_o && !out_ready |=> ser_out_valid_o && $stable(ser_out_data_o))
        else begin assert_fail_cnt++; $error("ser_out word changed while stalled"); end

    dsp_out_hold: assert property (@(posedge stream_clk) disable iff (stream_rst)
        dsp_out_valid_o && !dsp_out_ready_i |=> dsp_out_valid_o && $stable(dsp_out_data_o))
        else begin assert_fail_cnt++; $error("dsp_out word changed while stalled"); end

    // second reset cycle onward, registers have been cleared
    reset_quiet: assert property (@(posedge stream_clk)
        stream_rst ##1 stream_rst |-> !eth_out_valid_o && !ser_out_valid_o
                                      && !dsp_out_valid_o && !cpu_inp_done_o)
        else begin assert_fail_cnt++; $error("output active during reset"); end

    ////////////////////
    // handshakes
    ////////////////////

    release_drops_done: assert property (@(posedge stream_clk) disable iff (stream_rst)
        cpu_inp_done_o && cpu_inp_release_i |=> !cpu_inp_done_o)
        else begin assert_fail_cnt++; $error("done still high after release"); end

    eth_implies_ser: assert property (@(posedge stream_clk) disable iff (stream_rst)
        eth_out_valid_o |-> ser_out_valid_o)
        else begin assert_fail_cnt++; $error("eth_out valid without ser_out valid"); end

endmodule

bind packet_router packet_router_props props_inst (
    .stream_clk        (stream_clk),
    .stream_rst        (stream_rst),
    .eth_out_data_o    (eth_out_data_o),
    .eth_out_valid_o   (eth_out_valid_o),
    .eth_out_ready_i   (eth_out_ready_i),
    .ser_out_data_o    (ser_out_data_o),
    .ser_out_valid_o   (ser_out_valid_o),
    .ser_out_ready_i   (ser_out_ready_i),
    .dsp_out_data_o    (dsp_out_data_o),
    .dsp_out_valid_o   (dsp_out_valid_o),
    .dsp_out_ready_i   (dsp_out_ready_i),
    .eth_link_up_i     (eth_link_up_i),
    .cpu_inp_release_i (cpu_inp_release_i),
    .cpu_inp_done_o    (cpu_inp_done_o)
);

`default_nettype wire

// ==== verif/packet_router_tb.sv ====
`timescale 1ns/1ps
`include "packet_router_config.svh"
`default_nettype none

module packet_router_tb import packet_router_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 20000;

    typedef frame_t frame_q_t [$];

    logic      stream_clk;
    logic      stream_rst;
    frame_t    eth_inp_data;
    frame_t    ser_inp_data;
    frame_t    eth_out_data;
    frame_t    ser_out_data;
    frame_t    dsp_out_data;
    logic      eth_inp_valid;
    logic      eth_inp_ready;
    logic      ser_inp_valid;
    logic      ser_inp_ready;
    logic      eth_out_valid;
    logic      eth_out_ready;
    logic      ser_out_valid;
    logic      ser_out_ready;
    logic      dsp_out_valid;
    logic      dsp_out_ready;
    logic      eth_link_up;
    logic      cpu_inp_release;
    logic      cpu_inp_done;
    logic      cpu_wr_en;
    logic      cpu_out_start;
    logic      cpu_out_idle;
    buf_addr_t cpu_inp_count;
    buf_addr_t cpu_rd_addr;
    buf_addr_t cpu_wr_addr;
    buf_addr_t cpu_out_count;
    payload_t  cpu_rd_data;
    payload_t  cpu_wr_data;

    logic        dsp_rand;     // random ready throttling
    logic        eth_rand;
    logic        ser_rand;
    frame_q_t    dsp_q;        // words seen leaving the router
    frame_q_t    out_q;
    int          check_errs;
    int          err_base;
    int          tests_passed;
    int          tests_failed;
    int          cycle_cnt;
    int unsigned seed_val;
    string       cur_test;

    packet_router packet_router_inst (
        .stream_clk        (stream_clk),
        .stream_rst        (stream_rst),
        .eth_inp_data_i    (eth_inp_data),
        .eth_inp_valid_i   (eth_inp_valid),
        .eth_inp_ready_o   (eth_inp_ready),
        .ser_inp_data_i    (ser_inp_data),
        .ser_inp_valid_i   (ser_inp_valid),
        .ser_inp_ready_o   (ser_inp_ready),
        .eth_out_data_o    (eth_out_data),
        .eth_out_valid_o   (eth_out_valid),
        .eth_out_ready_i   (eth_out_ready),
        .ser_out_data_o    (ser_out_data),
        .ser_out_valid_o   (ser_out_valid),
        .ser_out_ready_i   (ser_out_ready),
        .dsp_out_data_o    (dsp_out_data),
        .dsp_out_valid_o   (dsp_out_valid),
        .dsp_out_ready_i   (dsp_out_ready),
        .eth_link_up_i     (eth_link_up),
        .cpu_inp_release_i (cpu_inp_release),
        .cpu_inp_done_o    (cpu_inp_done),
        .cpu_inp_count_o   (cpu_inp_count),
        .cpu_rd_addr_i     (cpu_rd_addr),
        .cpu_rd_data_o     (cpu_rd_data),
        .cpu_wr_en_i       (cpu_wr_en),
        .cpu_wr_addr_i     (cpu_wr_addr),
        .cpu_wr_data_i     (cpu_wr_data),
        .cpu_out_count_i   (cpu_out_count),
        .cpu_out_start_i   (cpu_out_start),
        .cpu_out_idle_o    (cpu_out_idle)
    );

    initial begin
        stream_clk = 1'b0;
        forever #4 stream_clk = ~stream_clk;
    end

    always begin
        @(posedge stream_clk);
        #1;
        if (dsp_rand) dsp_out_ready = ($urandom % 4) != 0;
        if (eth_rand) eth_out_ready = ($urandom % 4) != 0;
        if (ser_rand) ser_out_ready = ($urandom % 4) != 0;
    end

    // a transfer seen mid-cycle lands on the next rising edge
    always @(negedge stream_clk) begin
        if (!stream_rst) begin
            if (dsp_out_valid && dsp_out_ready) dsp_q.push_back(dsp_out_data);
            if (eth_link_up && eth_out_valid && eth_out_ready)
                out_q.push_back(eth_out_data);
            if (!eth_link_up && ser_out_valid && ser_out_ready)
                out_q.push_back(ser_out_data);
        end
    end

    ////////////////////
    // helpers
    ////////////////////

    function automatic frame_t build_word(input logic sof, input logic eof, input payload_t pl);
        return {2'b00, eof, sof, pl};
    endfunction

    // with_hdr puts the udp data match fields into words 3, 6, 9 and 11
    function automatic frame_q_t make_packet(input int len, input bit with_hdr,
                                             input logic [15:0] port);
        frame_q_t pkt;
        payload_t pl;
        for (int i = 0; i < len; i++) begin
            pl = $urandom;
            if (with_hdr) begin
                case (i)
                    3:  pl[15:0]  = `PR_ETHERTYPE_IP;
                    6:  pl[23:16] = `PR_PROTO_UDP;
                    9:  pl[15:0]  = port;
                    11: pl[0]     = 1'b1;
                    default: ;
                endcase
            end
            pkt.push_back(build_word(i == 0, i == len - 1, pl));
        end
        return pkt;
    endfunction

    task automatic check_val(input string what, input logic [35:0] exp, input logic [35:0] act);
        assert (act === exp) else begin
            $display("[FAIL] %s %s: expected %h, actual %h", cur_test, what, exp, act);
            check_errs++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        err_base = check_errs + packet_router_inst.props_inst.assert_fail_cnt;
    endtask

    task automatic finish_test();
        int errs;
        errs = check_errs + packet_router_inst.props_inst.assert_fail_cnt - err_base;
        if (errs == 0) begin
            tests_passed++;
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, errs);
        end
    endtask

    task automatic send_packet(input bit on_ser, input frame_q_t pkt);
        foreach (pkt[i]) begin
            @(posedge stream_clk);
            #1;
            if (on_ser) begin
                ser_inp_data  = pkt[i];
                ser_inp_valid = 1'b1;
            end else begin
                eth_inp_data  = pkt[i];
                eth_inp_valid = 1'b1;
            end
            do @(negedge stream_clk); while (!(on_ser ? ser_inp_ready : eth_inp_ready));
        end
        @(posedge stream_clk);
        #1;
        if (on_ser) ser_inp_valid = 1'b0;
        else eth_inp_valid = 1'b0;
    endtask

    // wait for a stored packet, read it back, then release the buffer
    task automatic collect_cpu(input frame_q_t exp);
        do @(negedge stream_clk); while (!cpu_inp_done);
        check_val("count", exp.size(), cpu_inp_count);
        foreach (exp[i]) begin
            @(posedge stream_clk);
            #1 cpu_rd_addr = buf_addr_t'(i);
            @(posedge stream_clk);
            @(negedge stream_clk);
            check_val($sformatf("cpu word %0d", i), exp[i][31:0], cpu_rd_data);
        end
        @(posedge stream_clk);
        #1 cpu_inp_release = 1'b1;
        @(posedge stream_clk);
        @(negedge stream_clk);
        check_val("done after release", 1'b0, cpu_inp_done);
        @(posedge stream_clk);
        #1 cpu_inp_release = 1'b0;
    endtask

    task automatic collect_stream(input frame_q_t exp, input bit from_dsp);
        do @(posedge stream_clk); while ((from_dsp ? dsp_q.size() : out_q.size()) < exp.size());
        foreach (exp[i]) begin
            if (from_dsp) check_val($sformatf("dsp word %0d", i), exp[i], dsp_q[i]);
            else check_val($sformatf("out word %0d", i), exp[i], out_q[i]);
        end
    endtask

    task automatic play_out(input bit link_up);
        frame_q_t exp;
        out_q.delete();
        for (int i = 0; i < 8; i++) begin
            @(posedge stream_clk);
            #1;
            cpu_wr_en   = 1'b1;
            cpu_wr_addr = buf_addr_t'(i);
            cpu_wr_data = $urandom;
            exp.push_back(build_word(i == 0, i == 7, cpu_wr_data));
        end
        @(posedge stream_clk);
        #1;
        cpu_wr_en   = 1'b0;
        eth_link_up = link_up;
        eth_rand    = link_up;
        ser_rand    = !link_up;
        if (link_up) ser_out_ready = 1'b0;    // the idle link never paces
        else eth_out_ready = 1'b0;
        do @(negedge stream_clk); while (!cpu_out_idle);
        @(posedge stream_clk);
        #1;
        cpu_out_count   = buf_addr_t'(8);
        cpu_out_start   = 1'b1;
        @(posedge stream_clk);
        #1 cpu_out_start = 1'b0;
        collect_stream(exp, 1'b0);
        do @(negedge stream_clk); while (!cpu_out_idle);
        check_val("out word count", 8, out_q.size());
        eth_rand = 1'b0;
        ser_rand = 1'b0;
    endtask

    ////////////////////
    // test sequence
    ////////////////////

    initial begin
        frame_q_t pkt;
        frame_q_t pkt_b;
        frame_q_t exp;
        seed_val      = $urandom(32'hddc8);
        stream_rst    = 1'b1;
        {eth_inp_data, ser_inp_data, eth_inp_valid, ser_inp_valid} = '0;
        {eth_out_ready, ser_out_ready, dsp_out_ready, eth_link_up} = 4'b1111;
        {cpu_inp_release, cpu_wr_en, cpu_out_start} = '0;
        {cpu_rd_addr, cpu_wr_addr, cpu_wr_data, cpu_out_count} = '0;
        {dsp_rand, eth_rand, ser_rand} = '0;
        {check_errs, tests_passed, tests_failed} = '0;
        repeat (16) @(posedge stream_clk);
        #1 stream_rst = 1'b0;

        start_test("cpu_route");
        pkt = make_packet(6, 1'b0, 16'h0);
        fork
            send_packet(1'b0, pkt);
            collect_cpu(pkt);
        join
        finish_test();

        start_test("dsp_route");
        pkt = make_packet(20, 1'b1, `PR_UDP_DATA_PORT);
        exp.delete();
        for (int i = `PR_DSP_OFFSET; i < 20; i++)
            exp.push_back(build_word(i == `PR_DSP_OFFSET, i == 19, pkt[i][31:0]));
        dsp_q.delete();
        dsp_rand = 1'b1;
        fork
            send_packet(1'b1, pkt);
            collect_stream(exp, 1'b1);
        join
        dsp_rand      = 1'b0;
        dsp_out_ready = 1'b1;
        check_val("cpu done", 1'b0, cpu_inp_done);
        finish_test();

        start_test("header_miss");
        pkt = make_packet(20, 1'b1, `PR_UDP_DATA_PORT + 16'd1);
        fork
            send_packet(1'b0, pkt);
            collect_cpu(pkt);
        join
        finish_test();

        start_test("no_interleave");
        pkt   = make_packet(7, 1'b0, 16'h0);
        pkt_b = make_packet(5, 1'b0, 16'h0);
        fork
            send_packet(1'b0, pkt);
            send_packet(1'b1, pkt_b);
            begin
                collect_cpu(pkt);       // ethernet wins the idle combiner
                collect_cpu(pkt_b);
            end
        join
        finish_test();

        start_test("cpu_out_play");
        play_out(1'b1);
        play_out(1'b0);
        finish_test();

        $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && packet_router_inst.props_inst.assert_fail_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge stream_clk);
            cycle_cnt++;
        end
        $display("run stopped after %0d cycles, test %s never finished", cycle_cnt, cur_test);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== packet_router.f ====
+incdir+hdl
hdl/packet_router_pkg.sv
hdl/stream_combiner.sv
hdl/com_inspector.sv
hdl/cpu_inp_buffer.sv
hdl/cpu_out_buffer.sv
hdl/packet_router.sv
verif/packet_router_props.sv
verif/packet_router_tb.sv

// ==== Bender.yml ====
package:
  name: packet_router

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/packet_router_pkg.sv
      - hdl/stream_combiner.sv
      - hdl/com_inspector.sv
      - hdl/cpu_inp_buffer.sv
      - hdl/cpu_out_buffer.sv
      - hdl/packet_router.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/packet_router_props.sv
      - verif/packet_router_tb.sv
